// ==== logic/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// operand and result width
`define EXEC_DATA_WIDTH 16

// operand address width, also the bus address width
`define EXEC_ADDR_WIDTH 8

// instructions held in the queue
`define EXEC_QUEUE_DEPTH 4

// cache lines, index is the low address bits
`define EXEC_CACHE_LINES 8

// shift amount bits taken from operand b
`define EXEC_SHAMT_WIDTH 4

// opcode field width
`define EXEC_OPCODE_WIDTH 3

// controller state width
`define EXEC_STATE_WIDTH 3

`endif

// ==== logic/exec_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

	// alu operations
	typedef enum logic [`EXEC_OPCODE_WIDTH-1:0] {
		NOP = 3'd0,
		ADD = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		OR  = 3'd4,
		XOR = 3'd5,
		SHL = 3'd6
	} exec_opcode_e;

	// fetch controller states
	typedef enum logic [`EXEC_STATE_WIDTH-1:0] {
		IDLE        = 3'd0,
		LOOKUP      = 3'd1,
		BUS_REQUEST = 3'd2,
		READ_A      = 3'd3,
		READ_B      = 3'd4,
		ISSUE       = 3'd5,
		RESULT_WAIT = 3'd6
	} exec_state_e;

	// one queued instruction, opcode in the top bits
	typedef struct packed {
		exec_opcode_e                opcode;
		logic [`EXEC_ADDR_WIDTH-1:0] src_a;
		logic [`EXEC_ADDR_WIDTH-1:0] src_b;
	} exec_instr_t;

	// alu output with flags
	typedef struct packed {
		logic [`EXEC_DATA_WIDTH-1:0] value;
		logic                        carry;
		logic                        zero;
	} exec_result_t;

endpackage

`default_nettype wire

// ==== logic/instr_queue.sv ====
`default_nettype none

`include "exec_config.svh"

module instr_queue
	import exec_pkg::*;
#(
	parameter int DEPTH = `EXEC_QUEUE_DEPTH
)
(
	input  wire         clk,
	input  wire         reset_in,
	input  wire         exec_instr_t instr,
	input  wire         instr_valid,
	output logic        instr_ready,
	output exec_instr_t head,
	output logic        head_valid,
	input  wire         pop
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// instruction storage
	exec_instr_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	// pointer wrap that also works for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// ready drops only when every entry is taken
	assign instr_ready = (count != CNT_W'(DEPTH));
	assign head_valid  = (count != '0);
	assign head        = mem[rd_ptr];

	assign wr_en = instr_valid && instr_ready;
	assign rd_en = pop && head_valid;

	always_ff @(posedge clk)
	begin
		if (reset_in)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			// simultaneous push and pop leaves count alone
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= instr;
	end

	// controller must not pop an empty queue
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_in)
		pop |-> head_valid);

	// a write into a full queue would overwrite the waiting head entry
	a_head_held: assert property (@(posedge clk) disable iff (reset_in)
		head_valid && !pop |=> head_valid && $stable(head));

endmodule

`default_nettype wire

// ==== logic/operand_cache.sv ====
`default_nettype none

`include "exec_config.svh"

module operand_cache
#(
	parameter int LINES = `EXEC_CACHE_LINES
)
(
	input  wire                         clk,
	input  wire                         reset_in,
	input  wire  [`EXEC_ADDR_WIDTH-1:0] addr_a,
	input  wire  [`EXEC_ADDR_WIDTH-1:0] addr_b,
	output logic                        hit_a,
	output logic                        hit_b,
	output logic [`EXEC_DATA_WIDTH-1:0] data_a,
	output logic [`EXEC_DATA_WIDTH-1:0] data_b,
	input  wire                         fill_en,
	input  wire  [`EXEC_ADDR_WIDTH-1:0] fill_addr,
	input  wire  [`EXEC_DATA_WIDTH-1:0] fill_data
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = `EXEC_ADDR_WIDTH - IDX_W;

	// per line state
	logic [LINES-1:0] line_valid;
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [`EXEC_DATA_WIDTH-1:0] data_mem [LINES];

	// address split for both lookup ports and the fill port
	logic [IDX_W-1:0] idx_a;
	logic [IDX_W-1:0] idx_b;
	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] tag_a;
	logic [TAG_W-1:0] tag_b;
	logic [TAG_W-1:0] fill_tag;

	assign idx_a    = addr_a[IDX_W-1:0];
	assign idx_b    = addr_b[IDX_W-1:0];
	assign fill_idx = fill_addr[IDX_W-1:0];
	assign tag_a    = addr_a[`EXEC_ADDR_WIDTH-1:IDX_W];
	assign tag_b    = addr_b[`EXEC_ADDR_WIDTH-1:IDX_W];
	assign fill_tag = fill_addr[`EXEC_ADDR_WIDTH-1:IDX_W];

	// combinational lookup, port a
	assign hit_a  = line_valid[idx_a] && (tag_mem[idx_a] == tag_a);
	assign data_a = data_mem[idx_a];

	// port b, same rule
	assign hit_b  = line_valid[idx_b] && (tag_mem[idx_b] == tag_b);
	assign data_b = data_mem[idx_b];

	// all lines invalid after reset
	always_ff @(posedge clk)
	begin
		if (reset_in)
			line_valid <= '0;
		else if (fill_en)
			line_valid[fill_idx] <= 1'b1;
	end

	// fill overwrites whatever sat at that index
	always_ff @(posedge clk)
	begin
		if (fill_en)
		begin
			tag_mem[fill_idx]  <= fill_tag;
			data_mem[fill_idx] <= fill_data;
		end
	end

	// an X address would corrupt a random line
	a_fill_addr_known: assert property (@(posedge clk) disable iff (reset_in)
		fill_en |-> !$isunknown(fill_addr));

endmodule

`default_nettype wire

// ==== logic/exec_alu.sv ====
`default_nettype none

`include "exec_config.svh"

module exec_alu
	import exec_pkg::*;
(
	input  wire                         clk,
	input  wire                         reset_in,
	input  wire                         issue,
	input  wire  exec_opcode_e          opcode,
	input  wire  [`EXEC_DATA_WIDTH-1:0] operand_a,
	input  wire  [`EXEC_DATA_WIDTH-1:0] operand_b,
	output logic                        done,
	output exec_result_t                result
);

	localparam int DW = `EXEC_DATA_WIDTH;

	logic [DW-1:0] value;
	logic carry;
	logic [2*DW-1:0] shifted;

	// bit DW of the wide shift holds the last bit pushed out
	assign shifted = {{DW{1'b0}}, operand_a} << operand_b[`EXEC_SHAMT_WIDTH-1:0];

	always_comb
	begin
		value = operand_a;
		carry = 1'b0;
		case (opcode)
			ADD: {carry, value} = {1'b0, operand_a} + {1'b0, operand_b};
			// top bit set here means a borrow
			SUB: {carry, value} = {1'b0, operand_a} - {1'b0, operand_b};
			AND: value = operand_a & operand_b;
			OR:  value = operand_a | operand_b;
			XOR: value = operand_a ^ operand_b;
			SHL:
			begin
				value = shifted[DW-1:0];
				carry = shifted[DW];
			end
			default:
			begin
				value = operand_a;
				carry = 1'b0;
			end
		endcase
	end

	// one cycle from issue to done
	always_ff @(posedge clk)
	begin
		if (reset_in)
			done <= 1'b0;
		else
			done <= issue;
	end

	// result holds until the next issue
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			result.value <= value;
			result.carry <= carry;
			result.zero  <= (value == '0);
		end
	end

endmodule

`default_nettype wire

// ==== logic/fetch_control.sv ====
`default_nettype none

`include "exec_config.svh"

module fetch_control
	import exec_pkg::*;
(
	input  wire                         clk,
	input  wire                         reset_in,
	input  wire  exec_instr_t           head,
	input  wire                         head_valid,
	output logic                        pop,
	output logic [`EXEC_ADDR_WIDTH-1:0] lookup_a,
	output logic [`EXEC_ADDR_WIDTH-1:0] lookup_b,
	input  wire                         hit_a,
	input  wire                         hit_b,
	input  wire  [`EXEC_DATA_WIDTH-1:0] data_a,
	input  wire  [`EXEC_DATA_WIDTH-1:0] data_b,
	output logic                        fill_en,
	output logic [`EXEC_ADDR_WIDTH-1:0] fill_addr,
	output logic [`EXEC_DATA_WIDTH-1:0] fill_data,
	output logic                        bus_request,
	input  wire                         bus_grant,
	output logic                        bus_read,
	output logic [`EXEC_ADDR_WIDTH-1:0] bus_addr,
	input  wire  [`EXEC_DATA_WIDTH-1:0] bus_data,
	output logic                        issue,
	output exec_opcode_e                opcode,
	output logic [`EXEC_DATA_WIDTH-1:0] operand_a,
	output logic [`EXEC_DATA_WIDTH-1:0] operand_b,
	input  wire                         done,
	input  wire  exec_result_t          alu_result,
	output logic                        result_valid,
	output exec_result_t                result,
	input  wire                         result_ready
);

	exec_state_e state;
	exec_state_e next_state;

	// current instruction and its operands
	exec_instr_t instr_q;
	logic [`EXEC_DATA_WIDTH-1:0] op_a_q;
	logic [`EXEC_DATA_WIDTH-1:0] op_b_q;
	// which operands still need a bus read
	logic need_a_q;
	logic need_b_q;
	logic same_addr;
	logic last_read;

	assign same_addr = (instr_q.src_a == instr_q.src_b);

	// data arriving now is the final read of this instruction
	assign last_read = (state == READ_B) || ((state == READ_A) && !need_b_q);

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (head_valid)
					next_state = LOOKUP;
			LOOKUP:
				if (hit_a && hit_b)
					next_state = ISSUE;
				else
					next_state = BUS_REQUEST;
			BUS_REQUEST:
				if (bus_grant)
					next_state = need_a_q ? READ_A : READ_B;
			READ_A:
				next_state = need_b_q ? READ_B : ISSUE;
			READ_B:
				next_state = ISSUE;
			ISSUE:
				next_state = RESULT_WAIT;
			RESULT_WAIT:
				if (result_ready)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_in)
		begin
			state       <= IDLE;
			bus_request <= 1'b0;
			need_a_q    <= 1'b0;
			need_b_q    <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == LOOKUP)
			begin
				bus_request <= !(hit_a && hit_b);
				need_a_q    <= !hit_a;
				// repeated address is covered by the read for a
				need_b_q    <= !hit_b && !(!hit_a && same_addr);
			end
			else if (last_read)
			begin
				// request falls the cycle after the last datum
				bus_request <= 1'b0;
			end
		end
	end

	// payload capture
	always_ff @(posedge clk)
	begin
		if ((state == IDLE) && head_valid)
			instr_q <= head;
		if (state == LOOKUP)
		begin
			if (hit_a)
				op_a_q <= data_a;
			if (hit_b)
				op_b_q <= data_b;
		end
		if (state == READ_A)
		begin
			op_a_q <= bus_data;
			if (same_addr)
				op_b_q <= bus_data;
		end
		if (state == READ_B)
			op_b_q <= bus_data;
	end

	// cache lookup on the latched addresses
	assign lookup_a = instr_q.src_a;
	assign lookup_b = instr_q.src_b;

	// every returned datum goes into the cache
	assign fill_en   = (state == READ_A) || (state == READ_B);
	assign fill_addr = (state == READ_A) ? instr_q.src_a : instr_q.src_b;
	assign fill_data = bus_data;

	// first read on grant, b read overlaps the a data cycle
	assign bus_read = ((state == BUS_REQUEST) && bus_grant) || ((state == READ_A) && need_b_q);
	assign bus_addr = ((state == BUS_REQUEST) && need_a_q) ? instr_q.src_a : instr_q.src_b;

	// alu side
	assign issue     = (state == ISSUE);
	assign opcode    = instr_q.opcode;
	assign operand_a = op_a_q;
	assign operand_b = op_b_q;

	// alu keeps its register until the next issue
	assign result_valid = (state == RESULT_WAIT);
	assign result       = alu_result;
	assign pop          = result_valid && result_ready;

	a_read_granted: assert property (@(posedge clk) disable iff (reset_in)
		bus_read |-> bus_grant);

	a_result_stable: assert property (@(posedge clk) disable iff (reset_in)
		result_valid && !result_ready |=> result_valid && $stable(result));

	// bus done before issue, alu answers as the result becomes visible
	a_issue_alone: assert property (@(posedge clk) disable iff (reset_in)
		issue |-> !bus_request ##1 (done && result_valid));

endmodule

`default_nettype wire

// ==== logic/exec_unit_top.sv ====
`default_nettype none

`include "exec_config.svh"

module exec_unit_top
	import exec_pkg::*;
(
	input  wire                         clk,
	input  wire                         reset_in,
	input  wire  exec_instr_t           instr,
	input  wire                         instr_valid,
	output logic                        instr_ready,
	output exec_result_t                result,
	output logic                        result_valid,
	input  wire                         result_ready,
	output logic                        bus_request,
	input  wire                         bus_grant,
	output logic                        bus_read,
	output logic [`EXEC_ADDR_WIDTH-1:0] bus_addr,
	input  wire  [`EXEC_DATA_WIDTH-1:0] bus_data
);

	// queue to controller
	exec_instr_t head;
	logic head_valid;
	logic pop;

	// controller to cache
	logic [`EXEC_ADDR_WIDTH-1:0] lookup_a;
	logic [`EXEC_ADDR_WIDTH-1:0] lookup_b;
	logic hit_a;
	logic hit_b;
	logic [`EXEC_DATA_WIDTH-1:0] data_a;
	logic [`EXEC_DATA_WIDTH-1:0] data_b;
	logic fill_en;
	logic [`EXEC_ADDR_WIDTH-1:0] fill_addr;
	logic [`EXEC_DATA_WIDTH-1:0] fill_data;

	// controller to alu
	logic issue;
	exec_opcode_e opcode;
	logic [`EXEC_DATA_WIDTH-1:0] operand_a;
	logic [`EXEC_DATA_WIDTH-1:0] operand_b;
	logic done;
	exec_result_t alu_result;

	instr_queue #(.DEPTH(`EXEC_QUEUE_DEPTH)) i_queue (
		.clk(clk), .reset_in(reset_in),
		.instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
		.head(head), .head_valid(head_valid), .pop(pop)
	);

	operand_cache #(.LINES(`EXEC_CACHE_LINES)) i_cache (
		.clk(clk), .reset_in(reset_in),
		.addr_a(lookup_a), .addr_b(lookup_b),
		.hit_a(hit_a), .hit_b(hit_b), .data_a(data_a), .data_b(data_b),
		.fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data)
	);

	fetch_control i_control (
		.clk(clk), .reset_in(reset_in),
		.head(head), .head_valid(head_valid), .pop(pop),
		.lookup_a(lookup_a), .lookup_b(lookup_b),
		.hit_a(hit_a), .hit_b(hit_b), .data_a(data_a), .data_b(data_b),
		.fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data),
		.bus_request(bus_request), .bus_grant(bus_grant), .bus_read(bus_read),
		.bus_addr(bus_addr), .bus_data(bus_data),
		.issue(issue), .opcode(opcode), .operand_a(operand_a), .operand_b(operand_b),
		.done(done), .alu_result(alu_result),
		.result_valid(result_valid), .result(result), .result_ready(result_ready)
	);

	exec_alu i_alu (
		.clk(clk), .reset_in(reset_in),
		.issue(issue), .opcode(opcode),
		.operand_a(operand_a), .operand_b(operand_b),
		.done(done), .result(alu_result)
	);

endmodule

`default_nettype wire

// ==== verification/bus_memory.sv ====
`default_nettype none

`include "exec_config.svh"

module bus_memory
(
	input  wire                         clk,
	input  wire                         reset_in,
	input  wire                         bus_request,
	output wire                         bus_grant,
	input  wire                         bus_read,
	input  wire  [`EXEC_ADDR_WIDTH-1:0] bus_addr,
	output wire  [`EXEC_DATA_WIDTH-1:0] bus_data
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_WAIT = 5;

	logic grant_q = 1'b0;
	logic [`EXEC_DATA_WIDTH-1:0] data_q = '0;
	// idle cycles still to go before the grant
	logic [2:0] wait_left = 3'd0;
	logic armed = 1'b0;
	logic [2:0] delay;

	assign bus_grant = grant_q;
	assign bus_data  = data_q;

	// memory rule, every address bit matters
	function automatic logic [`EXEC_DATA_WIDTH-1:0] word_at(
		input logic [`EXEC_ADDR_WIDTH-1:0] addr);
		logic [31:0] product;
		product = 32'(addr) * 32'h9e37 + 32'h1234;
		return product[`EXEC_DATA_WIDTH-1:0];
	endfunction

	// arbiter, grant held until the request falls
	always @(posedge clk)
	begin
		if (reset_in || !bus_request)
		begin
			grant_q <= 1'b0;
			armed   <= 1'b0;
		end
		else if (!grant_q)
		begin
			if (!armed)
			begin
				// fresh request, draw 0 to 5 idle cycles
				delay = 3'($urandom_range(MAX_WAIT, 0));
				armed <= 1'b1;
				if (delay == 3'd0)
					grant_q <= 1'b1;
				else
					wait_left <= delay - 3'd1;
			end
			else if (wait_left == 3'd0)
				grant_q <= 1'b1;
			else
				wait_left <= wait_left - 3'd1;
		end
	end

	// data one cycle after the address
	always @(posedge clk)
	begin
		if (bus_read)
			data_q <= word_at(bus_addr);
	end

endmodule

`default_nettype wire

// ==== verification/exec_unit_tb.sv ====
`default_nettype none

`include "exec_config.svh"

module exec_unit_tb
	import exec_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 8;
	localparam int DEPTH = `EXEC_QUEUE_DEPTH;
	localparam int LINES = `EXEC_CACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	localparam int DW = `EXEC_DATA_WIDTH;
	localparam int N_DIRECTED = 7;
	localparam int N_RANDOM = 60;
	localparam int N_TOTAL = N_DIRECTED + N_RANDOM + DEPTH + 2;
	localparam int HOLD_CYCLES = 6;
	// bus wait, two reads, issue, gaps and a long back-pressure stretch
	localparam int WORST_CYCLES = 48;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + HOLD_CYCLES + N_TOTAL * WORST_CYCLES;

	logic clk = 1'b0;
	logic reset_in;
	exec_instr_t instr;
	logic instr_valid;
	logic instr_ready;
	exec_result_t result;
	logic result_valid;
	logic result_ready = 1'b0;
	logic bus_request;
	logic bus_grant;
	logic bus_read;
	logic [`EXEC_ADDR_WIDTH-1:0] bus_addr;
	logic [`EXEC_DATA_WIDTH-1:0] bus_data;

	// reference model of instructions in acceptance order
	exec_instr_t expected_q [$];
	// bus reads still owed by the front instruction
	logic [`EXEC_ADDR_WIDTH-1:0] reads_q [$];
	logic model_valid [LINES];
	logic [`EXEC_ADDR_WIDTH-1:0] model_addr [LINES];
	logic prepared = 1'b0;
	logic front_missed = 1'b0;
	logic request_seen = 1'b0;
	logic result_valid_prev = 1'b0;
	int cycle_index = 0;
	int head_cycle = 0;
	int sent_count = 0;
	int completed_count = 0;
	// ready mode selects always ready, random or refusing
	logic [1:0] ready_mode = 2'd0;

	exec_unit_top i_dut (
		.clk(clk), .reset_in(reset_in),
		.instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
		.result(result), .result_valid(result_valid), .result_ready(result_ready),
		.bus_request(bus_request), .bus_grant(bus_grant), .bus_read(bus_read),
		.bus_addr(bus_addr), .bus_data(bus_data)
	);

	bus_memory i_memory (
		.clk(clk), .reset_in(reset_in),
		.bus_request(bus_request), .bus_grant(bus_grant), .bus_read(bus_read),
		.bus_addr(bus_addr), .bus_data(bus_data)
	);

	always #(PERIOD / 2) clk = ~clk;

	task automatic halt_with_failure();
		$display("tests failed");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic report_problem(input string what);
		$display("%0t ns: %s", $time, what);
		halt_with_failure();
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %0t ns %s: actual %0h expected %0h", $time, name, actual, expected);
			halt_with_failure();
		end
	endtask

	function automatic logic [DW-1:0] expected_word(input logic [`EXEC_ADDR_WIDTH-1:0] addr);
		logic [31:0] product;
		product = 32'(addr) * 32'h9e37 + 32'h1234;
		return product[DW-1:0];
	endfunction

	// alu rules including the flags
	function automatic exec_result_t alu_expect(input exec_opcode_e op,
		input logic [DW-1:0] a, input logic [DW-1:0] b);
		exec_result_t r;
		logic [DW:0] wide;
		logic [DW-1:0] out_bits;
		int sh;
		sh = int'(b[`EXEC_SHAMT_WIDTH-1:0]);
		r.carry = 1'b0;
		case (op)
			ADD:
			begin
				wide = {1'b0, a} + {1'b0, b};
				r.value = wide[DW-1:0];
				r.carry = wide[DW];
			end
			SUB:
			begin
				r.value = a - b;
				r.carry = (a < b);
			end
			AND: r.value = a & b;
			OR:  r.value = a | b;
			XOR: r.value = a ^ b;
			SHL:
			begin
				r.value = a << sh;
				// last bit out is a[DW-sh]
				out_bits = a >> (DW - sh);
				if (sh != 0)
					r.carry = out_bits[0];
			end
			default: r.value = a;
		endcase
		r.zero = (r.value == '0);
		return r;
	endfunction

	function automatic logic cache_holds(input logic [`EXEC_ADDR_WIDTH-1:0] addr);
		logic [IDX_W-1:0] idx;
		idx = addr[IDX_W-1:0];
		return model_valid[idx] && (model_addr[idx] == addr);
	endfunction

	// hits judged before this instruction's own fills
	task automatic prepare_front();
		exec_instr_t ins;
		logic hit_a;
		logic hit_b;
		logic [IDX_W-1:0] idx;
		assert (expected_q.size() != 0)
		else report_problem("DUT activity with no instruction outstanding");
		ins = expected_q[0];
		hit_a = cache_holds(ins.src_a);
		hit_b = cache_holds(ins.src_b);
		reads_q.delete();
		if (!hit_a)
			reads_q.push_back(ins.src_a);
		// a repeated missing address is read once
		if (!hit_b && !(!hit_a && (ins.src_a == ins.src_b)))
			reads_q.push_back(ins.src_b);
		foreach (reads_q[i])
		begin
			idx = reads_q[i][IDX_W-1:0];
			model_valid[idx] = 1'b1;
			model_addr[idx] = reads_q[i];
		end
		front_missed = (reads_q.size() != 0);
		prepared = 1'b1;
	endtask

	task automatic check_result();
		exec_instr_t ins;
		exec_result_t want;
		assert (expected_q.size() != 0)
		else report_problem("result delivered with no instruction outstanding");
		assert (reads_q.size() == 0)
		else report_problem("result delivered before all operand reads");
		ins = expected_q.pop_front();
		want = alu_expect(ins.opcode, expected_word(ins.src_a), expected_word(ins.src_b));
		compare_value("result.value", 32'(result.value), 32'(want.value));
		compare_value("result.carry", 32'(result.carry), 32'(want.carry));
		compare_value("result.zero", 32'(result.zero), 32'(want.zero));
		completed_count++;
		prepared = 1'b0;
		front_missed = 1'b0;
		request_seen = 1'b0;
	endtask

	// monitor sampling the values that settled before the edge
	always @(posedge clk)
	begin
		logic handshake;
		logic was_empty;
		handshake = 1'b0;
		cycle_index = cycle_index + 1;
		if (reset_in)
		begin
			foreach (model_valid[i])
				model_valid[i] = 1'b0;
			prepared = 1'b0;
			request_seen = 1'b0;
			result_valid_prev = 1'b0;
		end
		else
		begin
			was_empty = (expected_q.size() == 0);
			// queue holds every instruction not yet handed back
			compare_value("instr_ready", 32'(instr_ready), 32'(expected_q.size() != DEPTH));
			if (bus_request && !prepared)
				prepare_front();
			if (bus_request)
			begin
				assert (front_missed)
				else report_problem("bus_request raised although both operands hit");
				request_seen = 1'b1;
			end
			else if (request_seen && (reads_q.size() != 0))
				report_problem("bus_request fell before the last read");
			if (bus_read)
			begin
				if (!prepared)
					prepare_front();
				assert (reads_q.size() != 0)
				else report_problem("bus_read with no operand missing");
				compare_value("bus_addr", 32'(bus_addr), 32'(reads_q[0]));
				reads_q.delete(0);
			end
			if (result_valid && !result_valid_prev)
			begin
				if (!prepared)
					prepare_front();
				// two hits take 2 cycles to issue and 1 in the alu
				if (!front_missed)
					compare_value("result_valid latency", 32'(cycle_index - head_cycle), 32'd3);
			end
			if (result_valid && result_ready)
			begin
				check_result();
				handshake = 1'b1;
			end
			if (instr_valid && instr_ready)
				expected_q.push_back(instr);
			// a new front is visible at head from the next sample
			if ((handshake || was_empty) && (expected_q.size() != 0))
				head_cycle = cycle_index + 1;
			result_valid_prev = result_valid;
		end
	end

	bus_read_granted: assert property (@(posedge clk) disable iff (reset_in)
		bus_read |-> bus_grant)
		else report_problem("bus_read was high without bus_grant");

	result_held: assert property (@(posedge clk) disable iff (reset_in)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else report_problem("result changed or result_valid fell under back-pressure");

	// result_ready follows the mode
	always @(posedge clk)
	begin
		#DRIVE_DELAY;
		case (ready_mode)
			2'd0: result_ready = 1'b1;
			2'd1: result_ready = 1'($urandom_range(1, 0));
			default: result_ready = 1'b0;
		endcase
	end

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	// held stable until accepted
	task automatic send_instr(input exec_opcode_e op, input logic [7:0] a, input logic [7:0] b);
		logic taken;
		instr.opcode = op;
		instr.src_a = a;
		instr.src_b = b;
		instr_valid = 1'b1;
		do
		begin
			taken = instr_ready;
			idle_cycles(1);
		end
		while (!taken);
		instr_valid = 1'b0;
		sent_count++;
	endtask

	task automatic send_random();
		exec_opcode_e op;
		logic [7:0] a;
		logic [7:0] b;
		op = exec_opcode_e'(3'($urandom_range(6, 0)));
		// small range so indices collide and lines get reused
		a = 8'($urandom_range(31, 0));
		b = 8'($urandom_range(31, 0));
		if ($urandom_range(7, 0) == 0)
			b = a;
		send_instr(op, a, b);
	endtask

	task automatic drain();
		while (expected_q.size() != 0)
			idle_cycles(1);
	endtask

	initial
	begin
		void'($urandom(32'hafaf3884));
		reset_in = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset_in = 1'b0;
		compare_value("result_valid", 32'(result_valid), 32'd0);
		compare_value("bus_request", 32'(bus_request), 32'd0);
		compare_value("bus_read", 32'(bus_read), 32'd0);
		compare_value("instr_ready", 32'(instr_ready), 32'd1);

		// directed misses, hits, repeats and index conflicts
		send_instr(ADD, 8'h10, 8'h11);
		send_instr(SUB, 8'h10, 8'h11);
		send_instr(XOR, 8'h22, 8'h22);
		send_instr(AND, 8'h03, 8'h0b);
		send_instr(OR, 8'h03, 8'h0b);
		send_instr(SHL, 8'h22, 8'h10);
		send_instr(NOP, 8'h40, 8'h05);
		drain();

		// random traffic under random back-pressure
		ready_mode <= 2'd1;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			idle_cycles(int'($urandom_range(2, 0)));
			send_random();
		end
		drain();

		// refuse results until the queue is full
		ready_mode <= 2'd2;
		idle_cycles(1);
		for (int i = 0; i < DEPTH; i++)
			send_instr(ADD, 8'(8'h30 + i), 8'(8'h08 + i));
		idle_cycles(HOLD_CYCLES);
		compare_value("instr_ready", 32'(instr_ready), 32'd0);
		ready_mode <= 2'd1;
		send_instr(SUB, 8'h31, 8'h30);
		send_instr(SHL, 8'h33, 8'h33);
		drain();

		if ((completed_count == sent_count) && !result_valid)
		begin
			$display("all tests passed");
			$finish;
		end
		else
			report_problem("results missing or still offered after the last instruction");
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * PERIOD);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		halt_with_failure();
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/exec_pkg.sv
logic/instr_queue.sv
logic/operand_cache.sv
logic/exec_alu.sv
logic/fetch_control.sv
logic/exec_unit_top.sv
verification/bus_memory.sv
verification/exec_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = exec_unit_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
